/* source/synth_pkg.sv */
package synth_pkg;

    // engine dimensions
    localparam int VOICES             = 4;
    localparam int V_WIDTH            = 2;   // voice index width
    localparam int AUD_BIT_DEPTH      = 24;  // left and right words
    localparam int PHASE_WIDTH        = 16;
    localparam int VOICE_SAMPLE_WIDTH = 22;  // scaled saw of one voice

    // timing
    localparam int SAMPLE_DIV = 16;  // AUDIO_CLK cycles per sample frame

    // envelope
    localparam int LEVEL_MAX     = 255;
    localparam int RESET_ATTACK  = 16;
    localparam int RESET_RELEASE = 16;

    typedef enum logic [1:0] {
        ENV_IDLE,     // no note
        ENV_ATTACK,   // level rising
        ENV_SUSTAIN,  // held at LEVEL_MAX
        ENV_RELEASE   // level falling
    } env_state_t;

    // register map, 3 bit address field
    typedef enum logic [2:0] {
        REG_ATTACK  = 3'd0,
        REG_RELEASE = 3'd1,
        REG_PAN     = 3'd2,
        REG_VOLUME  = 3'd3
    } reg_adr_t;

endpackage

/* source/synth_regs.sv */
module synth_regs (
    input  logic                         AUDIO_CLK,
    input  logic                         rst_n,
    input  logic                         write,
    input  logic                         read,
    input  logic [2:0]                   adr,
    input  logic [7:0]                   synth_data_in,
    output logic [7:0]                   synth_data_out,
    output logic [7:0]                   attack_rate,
    output logic [7:0]                   release_rate,
    output logic [synth_pkg::VOICES-1:0] pan_mask,
    output logic [2:0]                   volume_shift
);

    logic [7:0] rd_mux;  // value selected by adr

    always_ff @(posedge AUDIO_CLK) begin
        if (!rst_n) begin
            attack_rate  <= 8'(synth_pkg::RESET_ATTACK);
            release_rate <= 8'(synth_pkg::RESET_RELEASE);
            pan_mask     <= '0;
            volume_shift <= '0;
        end else if (write) begin
            case (synth_pkg::reg_adr_t'(adr))
                synth_pkg::REG_ATTACK:  attack_rate  <= synth_data_in;
                synth_pkg::REG_RELEASE: release_rate <= synth_data_in;
                synth_pkg::REG_PAN:     pan_mask     <= synth_data_in[synth_pkg::VOICES-1:0];
                synth_pkg::REG_VOLUME:  volume_shift <= synth_data_in[2:0];
                default: ;  // unmapped, write ignored
            endcase
        end
    end

    always_comb begin
        case (synth_pkg::reg_adr_t'(adr))
            synth_pkg::REG_ATTACK:  rd_mux = attack_rate;
            synth_pkg::REG_RELEASE: rd_mux = release_rate;
            synth_pkg::REG_PAN:     rd_mux = 8'(pan_mask);     // upper bits zero
            synth_pkg::REG_VOLUME:  rd_mux = 8'(volume_shift);
            default:                rd_mux = 8'h00;
        endcase
    end

    // read data held until the next read strobe
    always_ff @(posedge AUDIO_CLK) begin
        if (!rst_n) begin
            synth_data_out <= 8'h00;
        end else if (read) begin
            synth_data_out <= rd_mux;
        end
    end

endmodule

/* source/note_event_sync.sv */
module note_event_sync (
    input  logic                          AUDIO_CLK,
    input  logic                          rst_n,
    input  logic                          note_on,
    input  logic [synth_pkg::V_WIDTH-1:0] cur_key_adr,
    input  logic [7:0]                    cur_key_val,
    input  logic [6:0]                    cur_vel_on,
    input  logic [synth_pkg::VOICES-1:0]  keys_on,
    output logic                          sample_tick,
    output logic [synth_pkg::VOICES-1:0]  voice_load,
    output logic [7:0]                    reg_key_val,
    output logic [6:0]                    reg_vel_on,
    output logic [synth_pkg::VOICES-1:0]  reg_keys_on
);

    localparam int DIV_W = $clog2(synth_pkg::SAMPLE_DIV);

    logic [DIV_W-1:0]              div_cnt;
    logic                          frame_end;  // last cycle of the frame
    logic                          pending;
    logic [synth_pkg::V_WIDTH-1:0] pend_adr;
    logic [7:0]                    pend_key;
    logic [6:0]                    pend_vel;

    assign frame_end = (div_cnt == DIV_W'(synth_pkg::SAMPLE_DIV - 1));

    // control side, tick and load bits issued together
    always_ff @(posedge AUDIO_CLK) begin
        if (!rst_n) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
            voice_load  <= '0;
            reg_keys_on <= '0;
            pending     <= 1'b0;
        end else begin
            div_cnt     <= div_cnt + 1'b1;  // wraps at SAMPLE_DIV
            sample_tick <= frame_end;
            voice_load  <= '0;
            if (frame_end) begin
                if (pending)
                    voice_load <= synth_pkg::VOICES'(1) << pend_adr;
                reg_keys_on <= keys_on;
                pending     <= 1'b0;
            end
            if (note_on)
                pending <= 1'b1;  // a late event rolls into the next frame
        end
    end

    // captured event, last note_on in the frame wins
    always_ff @(posedge AUDIO_CLK) begin
        if (note_on) begin
            pend_adr <= cur_key_adr;
            pend_key <= cur_key_val;
            pend_vel <= cur_vel_on;
        end
        if (frame_end) begin
            reg_key_val <= pend_key;
            reg_vel_on  <= pend_vel;
        end
    end

endmodule

/* source/voice_unit.sv */
module voice_unit (
    input  logic                                           AUDIO_CLK,
    input  logic                                           rst_n,
    input  logic                                           sample_tick,
    input  logic                                           load,
    input  logic [7:0]                                     key_val,
    input  logic [6:0]                                     vel_on,
    input  logic                                           key_held,
    input  logic [7:0]                                     attack_rate,
    input  logic [7:0]                                     release_rate,
    output logic signed [synth_pkg::VOICE_SAMPLE_WIDTH-1:0] voice_sample,
    output logic                                           voice_free
);

    localparam int PW = synth_pkg::PHASE_WIDTH;

    logic [PW-1:0]         phase;
    logic [PW-1:0]         phase_inc;
    logic [6:0]            vel;
    logic [7:0]            level;
    synth_pkg::env_state_t state;
    logic [8:0]            level_up;  // spare bit for saturation
    logic signed [7:0]     saw;
    logic signed [24:0]    prod;

    assign level_up = {1'b0, level} + {1'b0, attack_rate};

    always_ff @(posedge AUDIO_CLK) begin
        if (!rst_n) begin
            phase     <= '0;
            phase_inc <= '0;
            vel       <= '0;
            level     <= '0;
            state     <= synth_pkg::ENV_IDLE;
        end else if (sample_tick) begin
            if (load) begin
                phase_inc <= PW'(key_val) << 4;  // key times 16
                vel       <= vel_on;
                phase     <= '0;
                level     <= '0;  // silent for the first frame
                state     <= synth_pkg::ENV_ATTACK;
            end else begin
                phase <= phase + phase_inc;
                case (state)
                    synth_pkg::ENV_ATTACK: begin
                        if (!key_held) begin
                            state <= synth_pkg::ENV_RELEASE;
                        end else if (level_up >= 9'(synth_pkg::LEVEL_MAX)) begin
                            level <= 8'(synth_pkg::LEVEL_MAX);
                            state <= synth_pkg::ENV_SUSTAIN;
                        end else begin
                            level <= level_up[7:0];
                        end
                    end
                    synth_pkg::ENV_SUSTAIN: begin
                        if (!key_held)
                            state <= synth_pkg::ENV_RELEASE;
                    end
                    synth_pkg::ENV_RELEASE: begin
                        if (level <= release_rate) begin
                            level <= '0;  // floor, voice done
                            state <= synth_pkg::ENV_IDLE;
                        end else begin
                            level <= level - release_rate;
                        end
                    end
                    default: ;  // idle, phase keeps running
                endcase
            end
        end
    end

    // top phase byte minus 128 is the msb inverted
    assign saw = {~phase[PW-1], phase[PW-2 -: 7]};

    // saw * level * velocity, then >>> 2
    assign prod = saw * $signed({1'b0, level}) * $signed({1'b0, vel});
    assign voice_sample = prod[synth_pkg::VOICE_SAMPLE_WIDTH+1:2];

    assign voice_free = (state == synth_pkg::ENV_IDLE);

endmodule

/* source/voice_mixer.sv */
module voice_mixer (
    input  logic                                   AUDIO_CLK,
    input  logic                                   rst_n,
    input  logic                                   sample_tick,
    input  logic [synth_pkg::VOICES*synth_pkg::VOICE_SAMPLE_WIDTH-1:0] voice_samples,
    input  logic [synth_pkg::VOICES-1:0]           pan_mask,
    input  logic [2:0]                             volume_shift,
    output logic [synth_pkg::AUD_BIT_DEPTH-1:0]    lsound_out,
    output logic [synth_pkg::AUD_BIT_DEPTH-1:0]    rsound_out,
    output logic                                   sample_strobe
);

    localparam int AW = synth_pkg::AUD_BIT_DEPTH;
    localparam int SW = synth_pkg::VOICE_SAMPLE_WIDTH;

    logic                 tick_d;  // voices settled one cycle after the tick
    logic signed [AW-1:0] lsum;
    logic signed [AW-1:0] rsum;

    always_comb begin
        logic signed [AW-1:0] word;
        lsum = '0;
        rsum = '0;
        for (int i = 0; i < synth_pkg::VOICES; i++) begin
            word = AW'($signed(voice_samples[i*SW +: SW]));  // sign extend
            if (pan_mask[i])
                rsum = rsum + word;
            else
                lsum = lsum + word;
        end
    end

    always_ff @(posedge AUDIO_CLK) begin
        if (!rst_n) begin
            tick_d        <= 1'b0;
            sample_strobe <= 1'b0;
            lsound_out    <= '0;
            rsound_out    <= '0;
        end else begin
            tick_d        <= sample_tick;
            sample_strobe <= tick_d;  // strobe with the new words
            if (tick_d) begin
                lsound_out <= lsum >>> volume_shift;
                rsound_out <= rsum >>> volume_shift;
            end
        end
    end

endmodule

/* source/synth_engine.sv */
module synth_engine (
    input  logic                                AUDIO_CLK,
    input  logic                                rst_n,
    input  logic                                note_on,
    input  logic [synth_pkg::V_WIDTH-1:0]       cur_key_adr,
    input  logic [7:0]                          cur_key_val,
    input  logic [6:0]                          cur_vel_on,
    input  logic [synth_pkg::VOICES-1:0]        keys_on,
    input  logic                                write,
    input  logic                                read,
    input  logic [2:0]                          adr,
    input  logic [7:0]                          synth_data_in,
    output logic [7:0]                          synth_data_out,
    output logic [synth_pkg::AUD_BIT_DEPTH-1:0] lsound_out,
    output logic [synth_pkg::AUD_BIT_DEPTH-1:0] rsound_out,
    output logic                                sample_strobe,
    output logic [synth_pkg::VOICES-1:0]        voice_free
);

    localparam int SW = synth_pkg::VOICE_SAMPLE_WIDTH;

    logic [7:0]                          attack_rate;
    logic [7:0]                          release_rate;
    logic [synth_pkg::VOICES-1:0]        pan_mask;
    logic [2:0]                          volume_shift;
    logic                                sample_tick;
    logic [synth_pkg::VOICES-1:0]        voice_load;
    logic [7:0]                          reg_key_val;
    logic [6:0]                          reg_vel_on;
    logic [synth_pkg::VOICES-1:0]        reg_keys_on;
    logic [synth_pkg::VOICES*SW-1:0]     voice_samples;  // one word per voice

    synth_regs synth_regs_inst (
        .AUDIO_CLK      ( AUDIO_CLK ),
        .rst_n          ( rst_n ),
        .write          ( write ),
        .read           ( read ),
        .adr            ( adr ),
        .synth_data_in  ( synth_data_in ),
        .synth_data_out ( synth_data_out ),
        .attack_rate    ( attack_rate ),
        .release_rate   ( release_rate ),
        .pan_mask       ( pan_mask ),
        .volume_shift   ( volume_shift )
    );

    note_event_sync key_sync_inst (
        .AUDIO_CLK   ( AUDIO_CLK ),
        .rst_n       ( rst_n ),
        .note_on     ( note_on ),
        .cur_key_adr ( cur_key_adr ),
        .cur_key_val ( cur_key_val ),
        .cur_vel_on  ( cur_vel_on ),
        .keys_on     ( keys_on ),
        .sample_tick ( sample_tick ),
        .voice_load  ( voice_load ),
        .reg_key_val ( reg_key_val ),
        .reg_vel_on  ( reg_vel_on ),
        .reg_keys_on ( reg_keys_on )
    );

    for (genvar v = 0; v < synth_pkg::VOICES; v++) begin : voice_loop
        voice_unit voice_inst (
            .AUDIO_CLK    ( AUDIO_CLK ),
            .rst_n        ( rst_n ),
            .sample_tick  ( sample_tick ),
            .load         ( voice_load[v] ),
            .key_val      ( reg_key_val ),   // shared, only the loaded voice takes it
            .vel_on       ( reg_vel_on ),
            .key_held     ( reg_keys_on[v] ),
            .attack_rate  ( attack_rate ),
            .release_rate ( release_rate ),
            .voice_sample ( voice_samples[v*SW +: SW] ),
            .voice_free   ( voice_free[v] )
        );
    end

    voice_mixer mixer_inst (
        .AUDIO_CLK     ( AUDIO_CLK ),
        .rst_n         ( rst_n ),
        .sample_tick   ( sample_tick ),
        .voice_samples ( voice_samples ),
        .pan_mask      ( pan_mask ),
        .volume_shift  ( volume_shift ),
        .lsound_out    ( lsound_out ),
        .rsound_out    ( rsound_out ),
        .sample_strobe ( sample_strobe )
    );

endmodule

/* bench/synth_engine_properties.sv */
module synth_engine_properties (
    input logic                                AUDIO_CLK,
    input logic                                rst_n,
    input logic                                sample_strobe,
    input logic [synth_pkg::AUD_BIT_DEPTH-1:0] lsound_out,
    input logic [synth_pkg::AUD_BIT_DEPTH-1:0] rsound_out,
    input logic [synth_pkg::VOICES-1:0]        voice_free
);
    timeunit 1ns;
    timeprecision 1ps;

    strobe_single: assert property (@(posedge AUDIO_CLK) disable iff (!rst_n)
        sample_strobe |=> !sample_strobe)
        else $error("sample_strobe high in two consecutive cycles");

    // new audio words appear together with the strobe
    outputs_on_strobe: assert property (@(posedge AUDIO_CLK) disable iff (!rst_n)
        ($changed(lsound_out) || $changed(rsound_out)) |-> sample_strobe)
        else $error("audio output changed outside a strobe cycle");

    free_after_reset: assert property (@(posedge AUDIO_CLK)
        $rose(rst_n) |-> (voice_free == '1))
        else $error("voice_free not all ones after reset");

endmodule

bind synth_engine synth_engine_properties props_inst (
    .AUDIO_CLK     ( AUDIO_CLK ),
    .rst_n         ( rst_n ),
    .sample_strobe ( sample_strobe ),
    .lsound_out    ( lsound_out ),
    .rsound_out    ( rsound_out ),
    .voice_free    ( voice_free )
);

/* bench/synth_engine_tb.sv */
module synth_engine_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NV = synth_pkg::VOICES;
    localparam int AW = synth_pkg::AUD_BIT_DEPTH;
    localparam int ROWS = 35;
    localparam int FRAME_LIMIT = 2 * synth_pkg::SAMPLE_DIV + 8;  // cycles
    localparam int STROBE_NS = 20 * synth_pkg::SAMPLE_DIV;      // strobe period

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_NOTE, OP_RELEASE, OP_WAIT, OP_IDLE} op_t;

    typedef struct packed {
        op_t op;
        int  voice;   // voice or register address
        int  value;   // data, key or strobe count, -1 draws a random note
        int  vel;
        int  exp_val;
    } step_t;

    logic                          AUDIO_CLK;
    logic                          rst_n;
    logic                          note_on;
    logic [synth_pkg::V_WIDTH-1:0] cur_key_adr;
    logic [7:0]                    cur_key_val;
    logic [6:0]                    cur_vel_on;
    logic [NV-1:0]                 keys_on;
    logic                          write;
    logic                          read;
    logic [2:0]                    adr;
    logic [7:0]                    synth_data_in;
    logic [7:0]                    synth_data_out;
    logic [AW-1:0]                 lsound_out;
    logic [AW-1:0]                 rsound_out;
    logic                          sample_strobe;
    logic [NV-1:0]                 voice_free;

    // reference model of voices and register file
    int                    m_phase [NV];
    int                    m_inc [NV];
    int                    m_vel [NV];
    int                    m_level [NV];
    int                    m_att_cnt [NV];  // strobes spent in attack
    synth_pkg::env_state_t m_state [NV];
    int                    sh_attack;
    int                    sh_release;
    int                    sh_pan;
    int                    sh_vol;
    bit                    pend_valid;
    int                    pend_voice;
    int                    pend_key;
    int                    pend_vel;
    time                   last_strobe;  // zero until the first strobe
    int                    seed = 28;
    int                    value_errors = 0;
    int                    timeouts = 0;
    step_t                 steps [ROWS];

    synth_engine DUT (.*);

    initial begin
        AUDIO_CLK = 1'b0;
        forever #10 AUDIO_CLK = ~AUDIO_CLK;
    end

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic advance_envelope(input int v);
        case (m_state[v])
            synth_pkg::ENV_ATTACK: begin
                if (!keys_on[v]) begin
                    m_state[v] = synth_pkg::ENV_RELEASE;
                end else if (m_level[v] + sh_attack >= synth_pkg::LEVEL_MAX) begin
                    m_level[v] = synth_pkg::LEVEL_MAX;
                    m_state[v] = synth_pkg::ENV_SUSTAIN;
                    if (m_att_cnt[v] != (synth_pkg::LEVEL_MAX + sh_attack - 1) / sh_attack) begin
                        $display("FAIL %0t attack strobes voice %0d expected %0d got %0d", $time,
                                 v, (synth_pkg::LEVEL_MAX + sh_attack - 1) / sh_attack,
                                 m_att_cnt[v]);
                        value_errors++;
                    end
                end else begin
                    m_level[v] = m_level[v] + sh_attack;
                    m_att_cnt[v]++;
                end
            end
            synth_pkg::ENV_SUSTAIN: begin
                if (!keys_on[v])
                    m_state[v] = synth_pkg::ENV_RELEASE;
            end
            synth_pkg::ENV_RELEASE: begin
                if (m_level[v] <= sh_release) begin
                    m_level[v] = 0;
                    m_state[v] = synth_pkg::ENV_IDLE;
                end else begin
                    m_level[v] = m_level[v] - sh_release;
                end
            end
            default: ;
        endcase
    endtask

    // one sample frame of the model, compared with the strobed outputs
    task automatic model_step();
        int            v;
        int            saw;
        int            exp_l;
        int            exp_r;
        logic [NV-1:0] exp_free;
        exp_l = 0;
        exp_r = 0;
        for (v = 0; v < NV; v++) begin
            if (pend_valid && pend_voice == v) begin
                m_inc[v]     = pend_key * 16;
                m_vel[v]     = pend_vel;
                m_phase[v]   = 0;
                m_level[v]   = 0;
                m_att_cnt[v] = 1;
                m_state[v]   = synth_pkg::ENV_ATTACK;
            end else begin
                m_phase[v] = (m_phase[v] + m_inc[v]) % 65536;  // wraps at 16 bits
                advance_envelope(v);
            end
            saw = (m_phase[v] >> 8) - 128;
            if (sh_pan[v])
                exp_r = exp_r + ((saw * m_level[v] * m_vel[v]) >>> 2);
            else
                exp_l = exp_l + ((saw * m_level[v] * m_vel[v]) >>> 2);
            exp_free[v] = (m_state[v] == synth_pkg::ENV_IDLE);
        end
        pend_valid = 1'b0;
        exp_l = exp_l >>> sh_vol;
        exp_r = exp_r >>> sh_vol;
        if (lsound_out !== AW'(exp_l)) begin
            $display("FAIL %0t lsound_out expected %h got %h", $time, AW'(exp_l), lsound_out);
            value_errors++;
        end
        if (rsound_out !== AW'(exp_r)) begin
            $display("FAIL %0t rsound_out expected %h got %h", $time, AW'(exp_r), rsound_out);
            value_errors++;
        end
        if (voice_free !== exp_free) begin
            $display("FAIL %0t voice_free expected %b got %b", $time, exp_free, voice_free);
            value_errors++;
        end
    endtask

    // sample on the falling edge of the strobe cycle
    task automatic next_frame();
        int n;
        n = 0;
        do begin
            @(negedge AUDIO_CLK);
            n++;
        end while (sample_strobe !== 1'b1 && n < FRAME_LIMIT);
        if (sample_strobe !== 1'b1) begin
            $display("timeout: no sample_strobe within %0d cycles", FRAME_LIMIT);
            timeouts++;
            finish_run();
        end else begin
            if (last_strobe != 0 && $time - last_strobe != STROBE_NS) begin
                $display("FAIL %0t sample_strobe period expected %0d got %0d", $time,
                         STROBE_NS, $time - last_strobe);
                value_errors++;
            end
            last_strobe = $time;
            model_step();
        end
    endtask

    task automatic apply_step(input step_t s);
        int n;
        int predicted;
        if (s.op != OP_WAIT)
            next_frame();  // every operation starts right after a strobe
        case (s.op)
            OP_WRITE: begin
                write         = 1'b1;
                adr           = 3'(s.voice);
                synth_data_in = 8'(s.value);
                case (s.voice)
                    0: sh_attack  = s.value & 8'hff;
                    1: sh_release = s.value & 8'hff;
                    2: sh_pan     = s.value & ((1 << NV) - 1);
                    3: sh_vol     = s.value & 7;
                    default: ;
                endcase
                @(negedge AUDIO_CLK);
                write = 1'b0;
            end
            OP_READ: begin
                read = 1'b1;
                adr  = 3'(s.voice);
                @(negedge AUDIO_CLK);
                read = 1'b0;
                if (synth_data_out !== 8'(s.exp_val)) begin
                    $display("FAIL %0t synth_data_out expected %h got %h", $time,
                             8'(s.exp_val), synth_data_out);
                    value_errors++;
                end
            end
            OP_NOTE: begin
                pend_key   = (s.value < 0) ? ($random(seed) & 8'hff) : s.value;
                pend_vel   = (s.value < 0) ? ($random(seed) & 7'h7f) : s.vel;
                pend_voice = s.voice;
                pend_valid = 1'b1;
                keys_on[s.voice] = 1'b1;
                note_on     = 1'b1;
                cur_key_adr = synth_pkg::V_WIDTH'(s.voice);
                cur_key_val = 8'(pend_key);
                cur_vel_on  = 7'(pend_vel);
                @(negedge AUDIO_CLK);
                note_on = 1'b0;
            end
            OP_RELEASE: begin
                keys_on[s.voice] = 1'b0;
                predicted = 1 + (m_level[s.voice] + sh_release - 1) / sh_release;
                n = 0;
                while (voice_free[s.voice] !== 1'b1 && n < 64) begin
                    next_frame();
                    n++;
                end
                if (voice_free[s.voice] !== 1'b1) begin
                    $display("timeout: voice %0d still busy after 64 strobes", s.voice);
                    timeouts++;
                end else if (n != predicted) begin
                    $display("FAIL %0t release strobes voice %0d expected %0d got %0d", $time,
                             s.voice, predicted, n);
                    value_errors++;
                end
            end
            OP_WAIT: begin
                repeat (s.value) next_frame();
            end
            OP_IDLE: begin
                if (voice_free !== NV'(s.exp_val)) begin
                    $display("FAIL %0t voice_free expected %b got %b", $time,
                             NV'(s.exp_val), voice_free);
                    value_errors++;
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        rst_n         = 1'b0;
        note_on       = 1'b0;
        cur_key_adr   = '0;
        cur_key_val   = '0;
        cur_vel_on    = '0;
        keys_on       = '0;
        write         = 1'b0;
        read          = 1'b0;
        adr           = '0;
        synth_data_in = '0;
        for (int v = 0; v < NV; v++) begin
            m_phase[v]   = 0;
            m_inc[v]     = 0;
            m_vel[v]     = 0;
            m_level[v]   = 0;
            m_att_cnt[v] = 0;
            m_state[v]   = synth_pkg::ENV_IDLE;
        end
        sh_attack   = synth_pkg::RESET_ATTACK;
        sh_release  = synth_pkg::RESET_RELEASE;
        sh_pan      = 0;
        sh_vol      = 0;
        pend_valid  = 1'b0;
        last_strobe = 0;
        steps = '{
            '{OP_WAIT, 0, 3, 0, 0},   '{OP_READ, 0, 0, 0, 16},     '{OP_READ, 1, 0, 0, 16},
            '{OP_READ, 2, 0, 0, 0},   '{OP_READ, 3, 0, 0, 0},      '{OP_READ, 5, 0, 0, 0},
            '{OP_IDLE, 0, 0, 0, 15},  '{OP_WRITE, 0, 40, 0, 0},    '{OP_WRITE, 1, 48, 0, 0},
            '{OP_WRITE, 2, 165, 0, 0}, '{OP_WRITE, 3, 249, 0, 0},  '{OP_READ, 0, 0, 0, 40},
            '{OP_READ, 1, 0, 0, 48},  '{OP_READ, 2, 0, 0, 5},      '{OP_READ, 3, 0, 0, 1},
            '{OP_WRITE, 2, 0, 0, 0},  '{OP_WRITE, 3, 0, 0, 0},     '{OP_NOTE, 0, 50, 100, 0},
            '{OP_IDLE, 0, 0, 0, 14},  '{OP_WAIT, 0, 10, 0, 0},     '{OP_WRITE, 2, 1, 0, 0},
            '{OP_WAIT, 0, 4, 0, 0},   '{OP_WRITE, 3, 2, 0, 0},     '{OP_WRITE, 2, 6, 0, 0},
            '{OP_NOTE, 1, -1, 0, 0},  '{OP_NOTE, 2, -1, 0, 0},     '{OP_NOTE, 3, -1, 0, 0},
            '{OP_NOTE, 0, -1, 0, 0},  '{OP_WAIT, 0, 12, 0, 0},     '{OP_RELEASE, 0, 0, 0, 0},
            '{OP_RELEASE, 1, 0, 0, 0}, '{OP_RELEASE, 2, 0, 0, 0},  '{OP_RELEASE, 3, 0, 0, 0},
            '{OP_WAIT, 0, 3, 0, 0},   '{OP_IDLE, 0, 0, 0, 15}
        };
        repeat (3) @(negedge AUDIO_CLK);  // three reset cycles
        rst_n = 1'b1;
        for (int i = 0; i < ROWS; i++)
            apply_step(steps[i]);
        finish_run();
    end

endmodule

/* synth_engine.f */
source/synth_pkg.sv
source/synth_regs.sv
source/note_event_sync.sv
source/voice_unit.sv
source/voice_mixer.sv
source/synth_engine.sv
bench/synth_engine_properties.sv
bench/synth_engine_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = synth_engine_tb
FILELIST  = synth_engine.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
